/* src.f */
verilog/rvc_pkg.sv
verilog/rvc_quadrant0.sv
verilog/rvc_quadrant1.sv
verilog/rvc_quadrant2.sv
verilog/rvc_expander.sv
testbench/rvc_expander_asserts.sv
testbench/rvc_expander_tb.sv

/* Bender.yml */
package:
  name: rvc_expander

sources:
  - files:
      - verilog/rvc_pkg.sv
      - verilog/rvc_quadrant0.sv
      - verilog/rvc_quadrant1.sv
      - verilog/rvc_quadrant2.sv
      - verilog/rvc_expander.sv
  - target: test
    files:
      - testbench/rvc_expander_asserts.sv
      - testbench/rvc_expander_tb.sv

/* testbench/rvc_expander_tb.sv */
// RVC expander testbench
// table of compressed instructions with their RV32I expansions,
// random full-width words and valid timing checks

`timescale 1ns/1ps

module rvc_expander_tb;

  localparam int unsigned gap_index     = 20;
  localparam int unsigned random_count  = 200;
  localparam int unsigned drain_timeout = 20;

  // expected response of one accepted word
  typedef struct packed {
    logic [31:0] instr;
    logic        illegal;
    logic        compressed;
  } expect_t;

  logic        clk;
  logic        reset_i;
  logic        valid_i;
  logic [31:0] instr_i;
  logic        valid_o;
  logic [31:0] instr_o;
  logic        illegal_o;
  logic        is_compressed_o;

  string       tbl_name[$];
  logic [15:0] tbl_insn[$];
  expect_t     tbl_exp[$];
  string       name_q[$];
  expect_t     exp_q[$];
  logic [31:0] rng_state;
  logic        valid_prev;

  rvc_expander i_rvc_expander (
    .clk             (clk),
    .reset_i         (reset_i),
    .valid_i         (valid_i),
    .instr_i         (instr_i),
    .valid_o         (valid_o),
    .instr_o         (instr_o),
    .illegal_o       (illegal_o),
    .is_compressed_o (is_compressed_o)
  );

  bind rvc_expander rvc_expander_asserts i_rvc_expander_asserts (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic add_vector(input string name, input logic [15:0] insn,
                            input logic [31:0] instr, input logic illegal);
    expect_t exp;
    exp = '{instr: instr, illegal: illegal, compressed: 1'b1};
    tbl_name.push_back(name);
    tbl_insn.push_back(insn);
    tbl_exp.push_back(exp);
  endtask

  task automatic load_table();
    // quadrant 0
    add_vector("c.addi4spn",      16'h0800, 32'h0101_0413, 1'b0);
    add_vector("c.addi4spn_zero", 16'h0000, 32'h0,         1'b1);
    add_vector("c.lw",            16'h4144, 32'h0045_2483, 1'b0);
    add_vector("c.sw",            16'hc60c, 32'h00b6_2423, 1'b0);
    add_vector("q0_funct3_001",   16'h2000, 32'h0,         1'b1);
    add_vector("q0_funct3_011",   16'h6000, 32'h0,         1'b1);
    add_vector("q0_funct3_100",   16'h8000, 32'h0,         1'b1);
    add_vector("q0_funct3_101",   16'ha000, 32'h0,         1'b1);
    add_vector("q0_funct3_111",   16'he000, 32'h0,         1'b1);
    // quadrant 1
    add_vector("c.nop",           16'h0001, 32'h0000_0013, 1'b0);
    add_vector("c.addi",          16'h1575, 32'hffd5_0513, 1'b0);
    add_vector("c.li",            16'h429d, 32'h0070_0293, 1'b0);
    add_vector("c.lui",           16'h6785, 32'h0000_17b7, 1'b0);
    add_vector("c.lui_zero",      16'h6781, 32'h0,         1'b1);
    add_vector("c.addi16sp",      16'h6105, 32'h0201_0113, 1'b0);
    add_vector("c.addi16sp_neg",  16'h7139, 32'hfc01_0113, 1'b0);
    add_vector("c.srli",          16'h800d, 32'h0034_5413, 1'b0);
    add_vector("c.srai",          16'h8491, 32'h4044_d493, 1'b0);
    add_vector("c.srli_shamt5",   16'h900d, 32'h0,         1'b1);
    add_vector("c.srai_shamt5",   16'h9491, 32'h0,         1'b1);
    add_vector("c.andi",          16'h997d, 32'hfff5_7513, 1'b0);
    add_vector("c.sub",           16'h8c05, 32'h4094_0433, 1'b0);
    add_vector("c.xor",           16'h8d2d, 32'h00b5_4533, 1'b0);
    add_vector("c.or",            16'h8e55, 32'h00d6_6633, 1'b0);
    add_vector("c.and",           16'h8f7d, 32'h00f7_7733, 1'b0);
    add_vector("c.subw",          16'h9c05, 32'h0,         1'b1);
    add_vector("c.addw",          16'h9c25, 32'h0,         1'b1);
    add_vector("c.j",             16'ha021, 32'h0080_006f, 1'b0);
    add_vector("c.jal",           16'h3ffd, 32'hffff_f0ef, 1'b0);
    add_vector("c.beqz",          16'hc801, 32'h0004_0863, 1'b0);
    add_vector("c.bnez",          16'hfcf5, 32'hfe04_9ee3, 1'b0);
    // quadrant 2
    add_vector("c.slli",          16'h050a, 32'h0025_1513, 1'b0);
    add_vector("c.slli_shamt5",   16'h150a, 32'h0,         1'b1);
    add_vector("c.lwsp",          16'h40b2, 32'h00c1_2083, 1'b0);
    add_vector("c.lwsp_x0",       16'h4032, 32'h0,         1'b1);
    add_vector("c.jr",            16'h8082, 32'h0000_8067, 1'b0);
    add_vector("c.jr_x0",         16'h8002, 32'h0,         1'b1);
    add_vector("c.mv",            16'h852e, 32'h00b0_0533, 1'b0);
    add_vector("c.ebreak",        16'h9002, 32'h0010_0073, 1'b0);
    add_vector("c.jalr",          16'h9282, 32'h0002_80e7, 1'b0);
    add_vector("c.add",           16'h952e, 32'h00b5_0533, 1'b0);
    add_vector("c.swsp",          16'hc422, 32'h0081_2423, 1'b0);
  endtask

  task automatic drive_word(input string name, input logic [31:0] word, input expect_t exp);
    @(posedge clk);
    valid_i <= 1'b1;
    instr_i <= word;
    name_q.push_back(name);
    exp_q.push_back(exp);
  endtask

  task automatic drive_idle();
    @(posedge clk);
    valid_i <= 1'b0;
  endtask

  task automatic check_result();
    string   name;
    expect_t exp;
    if (exp_q.size() == 0) begin
      report_failure("valid_o went high with no input outstanding");
    end else begin
      name = name_q.pop_front();
      exp  = exp_q.pop_front();
      assert (is_compressed_o == exp.compressed) else
        report_failure($sformatf("ERROR %s is_compressed: expected %0b, actual %0b",
                                 name, exp.compressed, is_compressed_o));
      assert (illegal_o == exp.illegal) else
        report_failure($sformatf("ERROR %s illegal: expected %0b, actual %0b",
                                 name, exp.illegal, illegal_o));
      // expanded word is don't care for illegal encodings
      assert (exp.illegal || instr_o == exp.instr) else
        report_failure($sformatf("ERROR %s instr: expected %h, actual %h",
                                 name, exp.instr, instr_o));
    end
  endtask

  ////////////////////////////////////////////////////////////
  // output monitor, sampled mid-cycle
  ////////////////////////////////////////////////////////////

  initial begin
    valid_prev = 1'b0;
    // registered outputs are unknown before the first reset edge
    @(posedge clk);
    forever begin
      @(negedge clk);
      // valid_o low in reset, then one cycle behind valid_i
      assert (valid_o == valid_prev) else
        report_failure("valid_o did not follow valid_i by exactly one cycle");
      if (valid_o) begin
        check_result();
      end
      valid_prev = valid_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////

  initial begin
    logic [31:0] word;
    int unsigned wait_cycles;
    reset_i   <= 1'b1;
    valid_i   <= 1'b0;
    instr_i   <= 32'h0;
    rng_state  = 32'h17e679d7;
    load_table();
    repeat (10) @(posedge clk);
    reset_i <= 1'b0;

    // upper half is random and must not affect the expansion
    for (int i = 0; i < tbl_insn.size(); i++) begin
      if (i == gap_index) begin
        drive_idle();
      end
      rng_state = lcg_next(rng_state);
      word = {rng_state[31:16], tbl_insn[i]};
      drive_word(tbl_name[i], word, tbl_exp[i]);
    end
    drive_idle();

    // full-width words pass through unchanged
    for (int i = 0; i < random_count; i++) begin
      rng_state = lcg_next(rng_state);
      word = {rng_state[31:2], 2'b11};
      drive_word("pass_through", word, '{instr: word, illegal: 1'b0, compressed: 1'b0});
    end
    drive_idle();

    wait_cycles = 0;
    while (exp_q.size() != 0 && wait_cycles < drain_timeout) begin
      @(posedge clk);
      wait_cycles++;
    end
    if (exp_q.size() != 0) begin
      report_failure("timed out waiting for the last results on valid_o");
    end else begin
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

/* testbench/rvc_expander_asserts.sv */
// RVC expander assertions
// flag consistency, reset behavior and pass-through of full words

`timescale 1ns/1ps

module rvc_expander_asserts (
  input logic        clk,
  input logic        reset_i,
  input logic [31:0] instr_i,
  input logic        valid_o,
  input logic [31:0] instr_o,
  input logic        illegal_o,
  input logic        is_compressed_o
);

  // a full-width word is never illegal
  assert property (@(posedge clk) disable iff (reset_i) illegal_o |-> is_compressed_o)
    else $error("illegal_o set on a full-width word");

  assert property (@(posedge clk) reset_i |=> !valid_o)
    else $error("valid_o high one cycle after reset");

  assert property (@(posedge clk) disable iff (reset_i)
                   (valid_o && !is_compressed_o) |-> (instr_o == $past(instr_i)))
    else $error("full-width word changed on its way through");

endmodule

/* verilog/rvc_expander.sv */
// RVC expander top level
// expands a compressed fetch word or passes a full word through,
// result registered once as a decode-stage register

`timescale 1ns/1ps

module rvc_expander (
  input  logic        clk,
  input  logic        reset_i,
  input  logic        valid_i,
  input  logic [31:0] instr_i,
  output logic        valid_o,
  output logic [31:0] instr_o,
  output logic        illegal_o,
  output logic        is_compressed_o
);

  rvc_pkg::rvc_quadrant_e quadrant;
  rvc_pkg::rvc_result_t   q0_result;
  rvc_pkg::rvc_result_t   q1_result;
  rvc_pkg::rvc_result_t   q2_result;
  rvc_pkg::rvc_result_t   sel_result;
  rvc_pkg::rvc_result_t   result_q;
  logic                   valid_q;
  logic                   compressed_q;

  assign quadrant = rvc_pkg::rvc_quadrant_e'(instr_i[1:0]);

  ////////////////////////////////////////////////////////////
  // per-quadrant expansion
  ////////////////////////////////////////////////////////////

  rvc_quadrant0 i_rvc_quadrant0 (.insn_i(instr_i[15:0]), .result_o(q0_result));
  rvc_quadrant1 i_rvc_quadrant1 (.insn_i(instr_i[15:0]), .result_o(q1_result));
  rvc_quadrant2 i_rvc_quadrant2 (.insn_i(instr_i[15:0]), .result_o(q2_result));

  always_comb begin
    unique case (quadrant)
      rvc_pkg::q0: sel_result = q0_result;
      rvc_pkg::q1: sel_result = q1_result;
      rvc_pkg::q2: sel_result = q2_result;
      default: begin
        // 32-bit instruction, unchanged
        sel_result.instr   = instr_i;
        sel_result.illegal = 1'b0;
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // output register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q      <= 1'b0;
      result_q     <= '0;
      compressed_q <= 1'b0;
    end else begin
      valid_q      <= valid_i;
      result_q     <= sel_result;
      compressed_q <= (quadrant != rvc_pkg::q_full);
    end
  end

  assign valid_o         = valid_q;
  assign instr_o         = result_q.instr;
  assign illegal_o       = result_q.illegal;
  assign is_compressed_o = compressed_q;

endmodule

/* verilog/rvc_quadrant2.sv */
// RVC quadrant 2 expander
// c.slli, stack-pointer load/store and the jr/jalr/mv/add/ebreak group

`timescale 1ns/1ps

module rvc_quadrant2 (
  input  rvc_pkg::rvc_insn_t   insn_i,
  output rvc_pkg::rvc_result_t result_o
);

  // full register fields, no prime mapping in this quadrant
  logic [4:0] rd;
  logic [4:0] rs2;

  assign rd  = insn_i[11:7];
  assign rs2 = insn_i[6:2];

  always_comb begin
    result_o.instr   = 32'h0;
    result_o.illegal = 1'b0;

    unique case (insn_i[15:13])
      3'b000: begin
        // c.slli -> slli rd, rd, shamt
        result_o.instr   = {7'b0000000, rs2, rd, 3'b001, rd, rvc_pkg::opcode_opimm};
        result_o.illegal = insn_i[12];
      end

      3'b010: begin
        // c.lwsp -> lw rd, uimm(x2)
        result_o.instr = {4'b0000, insn_i[3:2], insn_i[12], insn_i[6:4], 2'b00,
                          rvc_pkg::reg_sp, 3'b010, rd, rvc_pkg::opcode_load};
        if (rd == rvc_pkg::reg_zero) begin
          result_o.illegal = 1'b1;
        end
      end

      3'b100: begin
        if (!insn_i[12]) begin
          if (rs2 == rvc_pkg::reg_zero) begin
            // c.jr -> jalr x0, 0(rs1), rs1 = x0 reserved
            result_o.instr = {12'h000, rd, 3'b000, rvc_pkg::reg_zero, rvc_pkg::opcode_jalr};
            if (rd == rvc_pkg::reg_zero) begin
              result_o.illegal = 1'b1;
            end
          end else begin
            // c.mv -> add rd, x0, rs2
            result_o.instr = {7'b0000000, rs2, rvc_pkg::reg_zero, 3'b000, rd, rvc_pkg::opcode_op};
          end
        end else begin
          if (rs2 == rvc_pkg::reg_zero) begin
            if (rd == rvc_pkg::reg_zero) begin
              result_o.instr = rvc_pkg::insn_ebreak;
            end else begin
              // c.jalr -> jalr x1, 0(rs1)
              result_o.instr = {12'h000, rd, 3'b000, rvc_pkg::reg_ra, rvc_pkg::opcode_jalr};
            end
          end else begin
            // c.add -> add rd, rd, rs2
            result_o.instr = {7'b0000000, rs2, rd, 3'b000, rd, rvc_pkg::opcode_op};
          end
        end
      end

      3'b110: begin
        // c.swsp -> sw rs2, uimm(x2)
        result_o.instr = {4'b0000, insn_i[8:7], insn_i[12], rs2, rvc_pkg::reg_sp, 3'b010,
                          insn_i[11:9], 2'b00, rvc_pkg::opcode_store};
      end

      // float, table jump and reserved slots
      default: begin
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

/* verilog/rvc_quadrant1.sv */
// RVC quadrant 1 expander
// immediate arithmetic, register ALU ops, jumps and branches

`timescale 1ns/1ps

module rvc_quadrant1 (
  input  rvc_pkg::rvc_insn_t   insn_i,
  output rvc_pkg::rvc_result_t result_o
);

  logic [4:0]  rd;
  logic [4:0]  rs1_p;
  logic [4:0]  rs2_p;
  logic [11:0] imm6_sext;

  assign rd    = insn_i[11:7];
  assign rs1_p = {rvc_pkg::creg_prefix, insn_i[9:7]};
  assign rs2_p = {rvc_pkg::creg_prefix, insn_i[4:2]};

  // 6-bit signed immediate of c.addi, c.li and c.andi
  assign imm6_sext = {{7{insn_i[12]}}, insn_i[6:2]};

  always_comb begin
    result_o.instr   = 32'h0;
    result_o.illegal = 1'b0;

    unique case (insn_i[15:13])
      3'b000: begin
        // c.addi -> addi rd, rd, imm (c.nop when rd = x0)
        result_o.instr = {imm6_sext, rd, 3'b000, rd, rvc_pkg::opcode_opimm};
      end

      3'b001, 3'b101: begin
        // c.jal links x1, c.j links x0
        result_o.instr = {insn_i[12], insn_i[8], insn_i[10:9], insn_i[6], insn_i[7],
                          insn_i[2], insn_i[11], insn_i[5:3], {9{insn_i[12]}},
                          insn_i[15] ? rvc_pkg::reg_zero : rvc_pkg::reg_ra,
                          rvc_pkg::opcode_jal};
      end

      3'b010: begin
        // c.li -> addi rd, x0, imm (rd = x0 is a hint)
        result_o.instr = {imm6_sext, rvc_pkg::reg_zero, 3'b000, rd, rvc_pkg::opcode_opimm};
      end

      3'b011: begin
        if (rd == rvc_pkg::reg_sp) begin
          // c.addi16sp -> addi x2, x2, nzimm*16
          result_o.instr = {{3{insn_i[12]}}, insn_i[4:3], insn_i[5], insn_i[2], insn_i[6],
                            4'b0000, rvc_pkg::reg_sp, 3'b000, rvc_pkg::reg_sp,
                            rvc_pkg::opcode_opimm};
        end else begin
          // c.lui -> lui rd, nzimm
          result_o.instr = {{15{insn_i[12]}}, insn_i[6:2], rd, rvc_pkg::opcode_lui};
        end
        if ({insn_i[12], insn_i[6:2]} == 6'b000000) begin
          result_o.illegal = 1'b1;
        end
      end

      3'b100: begin
        unique case (insn_i[11:10])
          2'b00, 2'b01: begin
            // c.srli / c.srai, shamt[5] must be clear on RV32
            result_o.instr = {1'b0, insn_i[10], 5'b00000, insn_i[6:2], rs1_p, 3'b101, rs1_p,
                              rvc_pkg::opcode_opimm};
            result_o.illegal = insn_i[12];
          end

          2'b10: begin
            // c.andi -> andi rd', rd', imm
            result_o.instr = {imm6_sext, rs1_p, 3'b111, rs1_p, rvc_pkg::opcode_opimm};
          end

          default: begin
            // register-register ops, funct2 in [6:5]
            unique case ({insn_i[12], insn_i[6:5]})
              3'b000: begin
                result_o.instr = {7'b0100000, rs2_p, rs1_p, 3'b000, rs1_p, rvc_pkg::opcode_op};
              end
              3'b001: begin
                result_o.instr = {7'b0000000, rs2_p, rs1_p, 3'b100, rs1_p, rvc_pkg::opcode_op};
              end
              3'b010: begin
                result_o.instr = {7'b0000000, rs2_p, rs1_p, 3'b110, rs1_p, rvc_pkg::opcode_op};
              end
              3'b011: begin
                result_o.instr = {7'b0000000, rs2_p, rs1_p, 3'b111, rs1_p, rvc_pkg::opcode_op};
              end
              // subw/addw are RV64 only, the rest is reserved
              default: begin
                result_o.illegal = 1'b1;
              end
            endcase
          end
        endcase
      end

      default: begin
        // c.beqz / c.bnez -> beq/bne rs1', x0, imm
        result_o.instr = {{4{insn_i[12]}}, insn_i[6:5], insn_i[2], rvc_pkg::reg_zero, rs1_p,
                          2'b00, insn_i[13], insn_i[11:10], insn_i[4:3], insn_i[12],
                          rvc_pkg::opcode_branch};
      end
    endcase
  end

endmodule

/* verilog/rvc_quadrant0.sv */
// RVC quadrant 0 expander
// c.addi4spn, c.lw and c.sw to their RV32I form

`timescale 1ns/1ps

module rvc_quadrant0 (
  input  rvc_pkg::rvc_insn_t   insn_i,
  output rvc_pkg::rvc_result_t result_o
);

  // rd' / rs2' in [4:2], rs1' in [9:7]
  logic [4:0] rd_p;
  logic [4:0] rs1_p;

  assign rd_p  = {rvc_pkg::creg_prefix, insn_i[4:2]};
  assign rs1_p = {rvc_pkg::creg_prefix, insn_i[9:7]};

  always_comb begin
    result_o.instr   = 32'h0;
    result_o.illegal = 1'b0;

    unique case (insn_i[15:13])
      3'b000: begin
        // c.addi4spn -> addi rd', x2, nzuimm
        result_o.instr = {2'b00, insn_i[10:7], insn_i[12:11], insn_i[5], insn_i[6], 2'b00,
                          rvc_pkg::reg_sp, 3'b000, rd_p, rvc_pkg::opcode_opimm};
        // zero immediate is reserved, all-zero half included
        if (insn_i[12:5] == 8'h00) begin
          result_o.illegal = 1'b1;
        end
      end

      3'b010: begin
        // c.lw -> lw rd', uimm(rs1')
        result_o.instr = {5'b00000, insn_i[5], insn_i[12:10], insn_i[6], 2'b00,
                          rs1_p, 3'b010, rd_p, rvc_pkg::opcode_load};
      end

      3'b110: begin
        // c.sw -> sw rs2', uimm(rs1')
        result_o.instr = {5'b00000, insn_i[5], insn_i[12], rd_p, rs1_p, 3'b010,
                          insn_i[11:10], insn_i[6], 2'b00, rvc_pkg::opcode_store};
      end

      // reserved, float and byte/half slots
      default: begin
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

/* verilog/rvc_pkg.sv */
// RVC expander package
// RV32 opcodes, register numbers and the types shared by the
// compressed instruction expander

package rvc_pkg;

  ////////////////////////////////////////////////////////////
  // RV32 major opcodes
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] opcode_opimm  = 7'h13;
  localparam logic [6:0] opcode_op     = 7'h33;
  localparam logic [6:0] opcode_lui    = 7'h37;
  localparam logic [6:0] opcode_load   = 7'h03;
  localparam logic [6:0] opcode_store  = 7'h23;
  localparam logic [6:0] opcode_branch = 7'h63;
  localparam logic [6:0] opcode_jal    = 7'h6f;
  localparam logic [6:0] opcode_jalr   = 7'h67;

  ////////////////////////////////////////////////////////////
  // register numbers
  ////////////////////////////////////////////////////////////

  // x0, link register and stack pointer
  localparam logic [4:0] reg_zero = 5'd0;
  localparam logic [4:0] reg_ra   = 5'd1;
  localparam logic [4:0] reg_sp   = 5'd2;

  // 3-bit compressed register fields map onto x8..x15
  localparam logic [1:0] creg_prefix = 2'b01;

  // full-width ebreak, target of c.ebreak
  localparam logic [31:0] insn_ebreak = 32'h0010_0073;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  // quadrant given by the two low bits of the fetch word
  typedef enum logic [1:0] {
    q0     = 2'b00,
    q1     = 2'b01,
    q2     = 2'b10,
    q_full = 2'b11
  } rvc_quadrant_e;

  // one compressed instruction half
  typedef logic [15:0] rvc_insn_t;

  // expansion result of one quadrant
  // instr is don't care whenever illegal is set
  typedef struct packed {
    logic [31:0] instr;
    logic        illegal;
  } rvc_result_t;

endpackage
